// File: xcvr_reconfig.f
xcvr_avmm_pkg.sv
xcvr_block_pkg.sv
avmm_arbiter.sv
cal_sequencer.sv
avmm_read_tracker.sv
xcvr_reconfig_top.sv
xcvr_reconfig_assertions.sv
tb_xcvr_reconfig.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the xcvr_reconfig testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_xcvr_reconfig -f xcvr_reconfig.f

# Keep running past assertion errors so the closing summary is printed
./obj_dir/Vtb_xcvr_reconfig +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: tb_xcvr_reconfig.sv
`timescale 1ns/1ps

module tb_xcvr_reconfig;

    // ****************************************
    // Run length
    // ****************************************
    localparam int NUM_RAND  = 12;                          // Random read/write pairs
    localparam int NUM_XFERS = 16 + 2 * NUM_RAND + 4;       // Block reads, random, cal test
    localparam int WATCHDOG_CYCLES = NUM_XFERS * 8 + 3 * xcvr_avmm_pkg::CAL_CYCLES + 50;

    logic                        avmm_clk;
    logic                        rst_n;
    xcvr_avmm_pkg::avmm_req_t    avmm_req;
    xcvr_avmm_pkg::data_t        avmm_readdata;
    logic                        avmm_waitrequest;
    logic                        avmm_busy;
    logic                        pld_cal_done;
    xcvr_avmm_pkg::avmm_req_t    chnl_req;
    xcvr_block_pkg::block_sel_t  block_select;
    xcvr_block_pkg::block_data_t block_readdata;

    integer                      seed;
    int                          rnd;
    int                          check_errors;
    int                          assert_errors;
    xcvr_avmm_pkg::addr_t        addr;
    xcvr_avmm_pkg::data_t        wdata;
    logic [3:0]                  blk;

    xcvr_reconfig_top xcvr_reconfig_top_inst (
        .avmm_clk         (avmm_clk),
        .rst_n            (rst_n),
        .avmm_req         (avmm_req),
        .avmm_readdata    (avmm_readdata),
        .avmm_waitrequest (avmm_waitrequest),
        .avmm_busy        (avmm_busy),
        .pld_cal_done     (pld_cal_done),
        .chnl_req         (chnl_req),
        .block_select     (block_select),
        .block_readdata   (block_readdata)
    );

    initial avmm_clk = 1'b0;
    always #20 avmm_clk = ~avmm_clk;                        // 40 ns period

    // ****************************************
    // Block models on the channel bus
    // ****************************************
    // Block k answers when address[8:5] is k, block 0 never answers
    always_comb begin
        block_select = '0;
        for (int k = 1; k < xcvr_block_pkg::NUM_BLOCKS; k++) begin
            if (int'(chnl_req.address[8:5]) == k) begin
                block_select[k] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int k = 0; k < xcvr_block_pkg::NUM_BLOCKS; k++) begin
            block_readdata[k] = block_select[k] ? xcvr_avmm_pkg::data_t'(k * 17) : '0;
        end
    end

    // Block k returns k*16+k, so both nibbles hold the block number
    function automatic xcvr_avmm_pkg::data_t expected_block_data(input xcvr_avmm_pkg::addr_t a);
        logic [3:0] k;
        k = a[8:5];
        if (k == 4'd0) begin
            return 8'h00;                                   // Nothing selected
        end
        return {k, k};
    endfunction

    task automatic check_value(input string name, input xcvr_avmm_pkg::data_t expected,
                               input xcvr_avmm_pkg::data_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s expected 0x%02h actual 0x%02h", name, expected, actual);
            check_errors++;
        end
    endtask

    // Negedge where waitrequest is low, the transfer completes on the next rising edge
    task automatic wait_ready();
        do begin
            @(negedge avmm_clk);
        end while (avmm_waitrequest);
    endtask

    task automatic wait_busy();
        do begin
            @(negedge avmm_clk);
        end while (!avmm_busy);
    endtask

    // ****************************************
    // Transfers
    // ****************************************
    task automatic drive_write(input xcvr_avmm_pkg::addr_t a, input xcvr_avmm_pkg::data_t d);
        @(posedge avmm_clk);
        avmm_req.write     <= 1'b1;
        avmm_req.address   <= a;
        avmm_req.writedata <= d;
        wait_ready();                                       // Held while stalled
        @(posedge avmm_clk);
        avmm_req.write     <= 1'b0;
    endtask

    task automatic write_xfer(input xcvr_avmm_pkg::addr_t a, input xcvr_avmm_pkg::data_t d);
        wait_ready();                                       // Bus idle first
        drive_write(a, d);
    endtask

    task automatic read_xfer(input string name, input xcvr_avmm_pkg::addr_t a,
                             input xcvr_avmm_pkg::data_t expected);
        wait_ready();
        @(posedge avmm_clk);
        avmm_req.read    <= 1'b1;
        avmm_req.address <= a;
        wait_ready();
        check_value(name, expected, avmm_readdata);         // Valid while waitrequest low
        @(posedge avmm_clk);
        avmm_req.read    <= 1'b0;
    endtask

    // ****************************************
    // Watchdog
    // ****************************************
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge avmm_clk);
        $display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ****************************************
    // Stimulus
    // ****************************************
    initial begin
        seed          = 32'h00136341;
        check_errors  = 0;
        assert_errors = 0;
        avmm_req      = '0;
        rst_n         = 1'b0;

        repeat (3) @(posedge avmm_clk);
        rst_n <= 1'b1;

        read_xfer("arb_reg_reset", xcvr_avmm_pkg::ARBITER_ADDR, 8'h00);

        // One read per block
        for (int k = 1; k < xcvr_block_pkg::NUM_BLOCKS; k++) begin
            blk  = k[3:0];
            addr = {blk, 5'h03};
            read_xfer($sformatf("block_%0d", k), addr, expected_block_data(addr));
        end
        read_xfer("no_block", 9'h015, 8'h00);

        // Random reads and plain writes
        for (int i = 0; i < NUM_RAND; i++) begin
            rnd  = $random(seed);
            addr = rnd[8:0];
            if (addr == xcvr_avmm_pkg::ARBITER_ADDR) begin
                addr = 9'h001;                              // Keep off the arbiter register
            end
            read_xfer("rand_read", addr, expected_block_data(addr));
            rnd   = $random(seed);
            addr  = rnd[8:0];
            wdata = rnd[16:9];
            if (addr == xcvr_avmm_pkg::ARBITER_ADDR) begin
                addr = 9'h002;
            end
            write_xfer(addr, wdata);
        end

        // Hand the bus to calibration, then stall a write behind it
        write_xfer(xcvr_avmm_pkg::ARBITER_ADDR, 8'h01);
        wait_busy();
        drive_write(9'h040, 8'ha5);                         // Completes once the bus is back
        check_value("cal_done", 8'h01, xcvr_avmm_pkg::data_t'(pld_cal_done));
        read_xfer("arb_reg_after_cal", xcvr_avmm_pkg::ARBITER_ADDR, 8'h02);

        repeat (5) @(posedge avmm_clk);
        assert_errors = xcvr_reconfig_top_inst.xcvr_reconfig_assertions_inst.fail_count;
        $display("Errors: %0d data check, %0d assertion", check_errors, assert_errors);
        if ((check_errors == 0) && (assert_errors == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: xcvr_reconfig_assertions.sv
`timescale 1ns/1ps

// Timing checks on the bridge bound into xcvr_reconfig_top
module xcvr_reconfig_assertions (
    input  logic                     avmm_clk,
    input  logic                     rst_n,
    input  xcvr_avmm_pkg::avmm_req_t avmm_req,
    input  logic                     avmm_waitrequest,
    input  logic                     avmm_busy,
    input  logic                     pld_cal_done,
    input  xcvr_avmm_pkg::avmm_req_t chnl_req,
    input  logic                     busy_r1,          // Internal busy stage
    input  logic                     wait_write        // Internal write stall
);

    int   fail_count = 0;                              // Assertion failures so far
    logic in_reset_r = 1'b0;                           // Reset already seen on a previous edge

    always @(posedge avmm_clk) begin
        in_reset_r <= !rst_n;
    end

    // ****************************************
    // Reset state
    // ****************************************
    a_reset_state: assert property (@(posedge avmm_clk)
        (!rst_n && in_reset_r) |-> (avmm_waitrequest && !avmm_busy && !pld_cal_done
                                    && !chnl_req.write && !chnl_req.read))
        else begin $error("Reset state wrong"); fail_count++; end

    // Waitrequest still high the first clock out of reset
    a_reset_exit: assert property (@(posedge avmm_clk)
        $rose(rst_n) |-> (avmm_waitrequest && !avmm_busy && !pld_cal_done))
        else begin $error("State after reset wrong"); fail_count++; end

    // ****************************************
    // Read latency of 4 stalled clocks then done
    // ****************************************
    a_read_latency: assert property (@(posedge avmm_clk) disable iff (!rst_n)
        ($rose(avmm_req.read) && !avmm_busy && !busy_r1 && !wait_write)
        |-> avmm_waitrequest ##1 avmm_waitrequest ##1 avmm_waitrequest
            ##1 avmm_waitrequest ##1 !avmm_waitrequest)
        else begin $error("Read latency wrong"); fail_count++; end

    // Read reaches the channel unless the engine owns the bus
    a_read_pass: assert property (@(posedge avmm_clk) disable iff (!rst_n)
        (avmm_req.read && !avmm_busy)
        |-> (chnl_req.read && (chnl_req.address == avmm_req.address)))
        else begin $error("Channel read wrong"); fail_count++; end

    // Plain write passes in its first clock with the same address and data on the channel
    a_write_pass: assert property (@(posedge avmm_clk) disable iff (!rst_n)
        (avmm_req.write && (avmm_req.address != xcvr_avmm_pkg::ARBITER_ADDR)
         && !avmm_busy && !wait_write && !avmm_req.read)
        |-> (!avmm_waitrequest && chnl_req.write
             && (chnl_req.address == avmm_req.address)
             && (chnl_req.writedata == avmm_req.writedata)))
        else begin $error("Channel write wrong"); fail_count++; end

    // ****************************************
    // Arbiter handover and calibration
    // ****************************************
    a_arb_stall: assert property (@(posedge avmm_clk) disable iff (!rst_n)
        (avmm_req.write && (avmm_req.address == xcvr_avmm_pkg::ARBITER_ADDR)
         && avmm_req.writedata[xcvr_avmm_pkg::ARB_CTRL_BIT] && !avmm_waitrequest)
        |=> avmm_waitrequest)
        else begin $error("No stall after arbiter write"); fail_count++; end

    a_busy_gate: assert property (@(posedge avmm_clk) disable iff (!rst_n)
        avmm_busy |-> (!chnl_req.write && !chnl_req.read))
        else begin $error("Channel strobe while busy"); fail_count++; end

    // Busy run is CAL_CYCLES long
    a_busy_len: assert property (@(posedge avmm_clk) disable iff (!rst_n)
        $fell(avmm_busy) |-> ($past(avmm_busy, xcvr_avmm_pkg::CAL_CYCLES)
                              && !$past(avmm_busy, xcvr_avmm_pkg::CAL_CYCLES + 1)))
        else begin $error("Busy length wrong"); fail_count++; end

    a_release: assert property (@(posedge avmm_clk) disable iff (!rst_n)
        $fell(avmm_busy) |-> pld_cal_done ##2 $fell(avmm_waitrequest))
        else begin $error("Bus release timing wrong"); fail_count++; end

endmodule

bind xcvr_reconfig_top xcvr_reconfig_assertions xcvr_reconfig_assertions_inst (
    .avmm_clk         (avmm_clk),
    .rst_n            (rst_n),
    .avmm_req         (avmm_req),
    .avmm_waitrequest (avmm_waitrequest),
    .avmm_busy        (avmm_busy),
    .pld_cal_done     (pld_cal_done),
    .chnl_req         (chnl_req),
    .busy_r1          (busy_r1),
    .wait_write       (wait_write)
);

// File: xcvr_reconfig_top.sv
`timescale 1ns/1ps

// Single-lane reconfiguration bridge
// User master -> arbiter gating -> shared channel bus -> blocks
// Block select/readdata -> read tracker -> user
module xcvr_reconfig_top (
    input  logic                        avmm_clk,
    input  logic                        rst_n,          // Synchronous, active low

    // User port
    input  xcvr_avmm_pkg::avmm_req_t    avmm_req,
    output xcvr_avmm_pkg::data_t        avmm_readdata,
    output logic                        avmm_waitrequest,

    // Calibration status
    output logic                        avmm_busy,      // Engine owns the bus
    output logic                        pld_cal_done,   // Sticky done flag

    // Channel bus to the blocks
    output xcvr_avmm_pkg::avmm_req_t    chnl_req,

    // Block returns
    input  xcvr_block_pkg::block_sel_t  block_select,
    input  xcvr_block_pkg::block_data_t block_readdata
);

    logic arb_ctrl;                                     // Arbiter register bit 0
    logic busy_r1;                                      // Busy, one clock late
    logic wait_write;                                   // Write stall during calibration
    logic cal_release;                                  // Clears arb_ctrl

    // ****************************************
    // Arbiter register and channel gating
    // ****************************************
    avmm_arbiter avmm_arbiter_inst (
        .avmm_clk    (avmm_clk),
        .rst_n       (rst_n),
        .avmm_req    (avmm_req),
        .avmm_busy   (avmm_busy),
        .cal_release (cal_release),
        .arb_ctrl    (arb_ctrl),
        .busy_r1     (busy_r1),
        .wait_write  (wait_write),
        .chnl_req    (chnl_req)
    );

    // Stand-in for the calibration engine
    cal_sequencer cal_sequencer_inst (
        .avmm_clk    (avmm_clk),
        .rst_n       (rst_n),
        .arb_ctrl    (arb_ctrl),
        .avmm_busy   (avmm_busy),
        .cal_done    (pld_cal_done),                    // Done flag goes straight out
        .cal_release (cal_release)
    );

    // ****************************************
    // Read latency, data select, waitrequest
    // ****************************************
    avmm_read_tracker avmm_read_tracker_inst (
        .avmm_clk         (avmm_clk),
        .rst_n            (rst_n),
        .avmm_req         (avmm_req),
        .busy_r1          (busy_r1),
        .wait_write       (wait_write),
        .arb_ctrl         (arb_ctrl),
        .cal_done         (pld_cal_done),
        .block_select     (block_select),
        .block_readdata   (block_readdata),
        .avmm_readdata    (avmm_readdata),
        .avmm_waitrequest (avmm_waitrequest)
    );

endmodule

// File: avmm_read_tracker.sv
`timescale 1ns/1ps

// Read latency counter, read data select, user waitrequest
module avmm_read_tracker (
    input  logic                        avmm_clk,
    input  logic                        rst_n,
    input  xcvr_avmm_pkg::avmm_req_t    avmm_req,
    input  logic                        busy_r1,          // Busy, one clock late
    input  logic                        wait_write,       // Write stall from the arbiter
    input  logic                        arb_ctrl,         // Arbiter register bit 0
    input  logic                        cal_done,         // Arbiter register bit 1
    input  xcvr_block_pkg::block_sel_t  block_select,
    input  xcvr_block_pkg::block_data_t block_readdata,
    output xcvr_avmm_pkg::data_t        avmm_readdata,
    output logic                        avmm_waitrequest
);

    logic                    read_r;                      // Read, one clock late
    logic                    wait_read;
    logic                    cnt_run;                     // Count in 1..READ_LATENCY
    logic                    cnt_start;                   // Counter may take a new read
    xcvr_avmm_pkg::read_cnt_t read_cnt;
    xcvr_avmm_pkg::data_t    sel_data;                    // Data for the current address

    assign cnt_run   = (read_cnt > 3'd0) && (read_cnt <= xcvr_avmm_pkg::READ_LATENCY);
    // Idle, or the clock a read completes, so held reads go back to back
    assign cnt_start = (read_cnt == 3'd0)
                       || (read_cnt == xcvr_avmm_pkg::READ_LATENCY + 3'd1);

    always_ff @(posedge avmm_clk) begin
        if (!rst_n) begin
            read_r <= 1'b0;
        end else begin
            read_r <= avmm_req.read;
        end
    end

    // ****************************************
    // Read counter
    // ****************************************
    // Reset value keeps waitrequest high, drops to 0 the clock after reset
    // Runs only while busy_r1 is low, otherwise back to 0
    always_ff @(posedge avmm_clk) begin
        if (!rst_n) begin
            read_cnt <= xcvr_avmm_pkg::READ_CNT_RST;
        end else if (!busy_r1 && avmm_req.read && cnt_start) begin
            read_cnt <= 3'd1;                             // New read
        end else if (!busy_r1 && cnt_run) begin
            read_cnt <= read_cnt + 1'b1;
        end else begin
            read_cnt <= 3'd0;
        end
    end

    // Rising read, running count, or reset
    assign wait_read = (avmm_req.read && !read_r)
                       || cnt_run
                       || (read_cnt == xcvr_avmm_pkg::READ_CNT_RST);

    assign avmm_waitrequest = wait_read || wait_write;

    // ****************************************
    // Read data select
    // ****************************************
    always_comb begin
        sel_data = '0;
        if (avmm_req.address == xcvr_avmm_pkg::ARBITER_ADDR) begin
            sel_data[xcvr_avmm_pkg::ARB_CTRL_BIT] = arb_ctrl;
            sel_data[xcvr_avmm_pkg::CAL_DONE_BIT] = cal_done;
        end else begin
            for (int i = 0; i < xcvr_block_pkg::NUM_BLOCKS; i++) begin
                if (block_select[i]) begin
                    sel_data = sel_data | block_readdata[i];  // Zero if none selected
                end
            end
        end
    end

    // Capture as the count passes READ_LATENCY, valid while waitrequest is low
    always_ff @(posedge avmm_clk) begin
        if (!busy_r1 && (read_cnt == xcvr_avmm_pkg::READ_LATENCY)) begin
            avmm_readdata <= sel_data;
        end
    end

endmodule

// File: cal_sequencer.sv
`timescale 1ns/1ps

// Calibration engine model
// Takes the bus when arb_ctrl is set, keeps it CAL_CYCLES clocks, then hands it back
module cal_sequencer (
    input  logic avmm_clk,
    input  logic rst_n,
    input  logic arb_ctrl,       // Bus handed over by the user
    output logic avmm_busy,      // High for the whole run
    output logic cal_done,       // Sticky after the first run
    output logic cal_release     // One clock pulse, clears arb_ctrl
);

    xcvr_block_pkg::cal_state_t state;
    xcvr_avmm_pkg::cal_cnt_t    cal_cnt;               // Clocks spent in CALIBRATE

    // ****************************************
    // Sequencer FSM
    // ****************************************
    always_ff @(posedge avmm_clk) begin
        if (!rst_n) begin
            state    <= xcvr_block_pkg::IDLE;
            cal_cnt  <= '0;
            cal_done <= 1'b0;
        end else begin
            case (state)
                xcvr_block_pkg::IDLE: begin
                    if (arb_ctrl) begin                // Request seen, start a run
                        state   <= xcvr_block_pkg::CALIBRATE;
                        cal_cnt <= '0;
                    end
                end
                xcvr_block_pkg::CALIBRATE: begin
                    if (cal_cnt == xcvr_avmm_pkg::CAL_CNT_LAST) begin
                        state    <= xcvr_block_pkg::RELEASE;
                        cal_done <= 1'b1;              // Set as busy drops
                    end else begin
                        cal_cnt <= cal_cnt + 1'b1;
                    end
                end
                xcvr_block_pkg::RELEASE: begin
                    state <= xcvr_block_pkg::IDLE;     // arb_ctrl clears on this edge
                end
                default: begin
                    state <= xcvr_block_pkg::IDLE;
                end
            endcase
        end
    end

    // Outputs decoded straight from state
    assign avmm_busy   = (state == xcvr_block_pkg::CALIBRATE);
    assign cal_release = (state == xcvr_block_pkg::RELEASE);

endmodule

// File: avmm_arbiter.sv
`timescale 1ns/1ps

// Arbiter register, busy pipeline, write stall, channel bus gating
module avmm_arbiter (
    input  logic                     avmm_clk,
    input  logic                     rst_n,
    input  xcvr_avmm_pkg::avmm_req_t avmm_req,     // User request held while stalled
    input  logic                     avmm_busy,    // From the calibration engine
    input  logic                     cal_release,  // Engine hands the bus back
    output logic                     arb_ctrl,     // 1 = calibration owns the bus
    output logic                     busy_r1,      // Busy delayed one clock
    output logic                     wait_write,   // Write waitrequest
    output xcvr_avmm_pkg::avmm_req_t chnl_req      // Gated request to the blocks
);

    logic busy_r2;                                 // Busy delayed two clocks
    logic arb_hit;                                 // Request targets the arbiter register
    logic arb_wr;                                  // Accepted write of 1 to bit 0

    assign arb_hit = (avmm_req.address == xcvr_avmm_pkg::ARBITER_ADDR);

    // Write accepted only when not already stalled
    assign arb_wr = avmm_req.write && arb_hit
                    && avmm_req.writedata[xcvr_avmm_pkg::ARB_CTRL_BIT]
                    && !wait_write;

    // ****************************************
    // Arbiter control bit
    // ****************************************
    always_ff @(posedge avmm_clk) begin
        if (!rst_n) begin
            arb_ctrl <= 1'b0;                      // User owns the bus after reset
        end else if (cal_release) begin
            arb_ctrl <= 1'b0;                      // Calibration finished
        end else if (arb_wr) begin
            arb_ctrl <= 1'b1;                      // User gives the bus away
        end
    end

    // Two-stage busy pipeline
    always_ff @(posedge avmm_clk) begin
        busy_r1 <= avmm_busy;
        busy_r2 <= busy_r1;
    end

    // ****************************************
    // Write waitrequest
    // ****************************************
    // Rises the clock after the arbiter write
    // Held across the gap before busy shows up in both stages
    // Then tracks busy_r1, so it falls two clocks after busy
    always_ff @(posedge avmm_clk) begin
        if (!rst_n) begin
            wait_write <= 1'b0;
        end else if (arb_wr) begin
            wait_write <= 1'b1;
        end else if (wait_write && !busy_r1 && !busy_r2) begin
            wait_write <= 1'b1;                    // Engine has not picked up yet
        end else begin
            wait_write <= busy_r1;
        end
    end

    // ****************************************
    // Channel bus
    // ****************************************
    always_comb begin
        chnl_req = avmm_req;                       // Address and data pass straight through
        if (avmm_busy) begin
            chnl_req.write = 1'b0;                 // Engine owns the bus
            chnl_req.read  = 1'b0;
        end
        if (arb_hit) begin
            chnl_req.write = 1'b0;                 // Arbiter register is local
        end
    end

endmodule

// File: xcvr_block_pkg.sv
package xcvr_block_pkg;

    // ****************************************
    // Configuration block fan-in
    // ****************************************

    // Dense block table for one lane, PMA, PCS and PLL blocks together
    localparam int NUM_BLOCKS = 16;

    // One select bit per block, at most one set at a time
    typedef logic [NUM_BLOCKS-1:0] block_sel_t;

    // Read data of every block, byte k belongs to block k
    typedef xcvr_avmm_pkg::data_t [NUM_BLOCKS-1:0] block_data_t;

    // ****************************************
    // Calibration sequencer
    // ****************************************

    // IDLE      user owns the bus
    // CALIBRATE engine owns the bus, busy high
    // RELEASE   one cycle, bus handed back
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        CALIBRATE = 2'd1,
        RELEASE   = 2'd2
    } cal_state_t;

endpackage

// File: xcvr_avmm_pkg.sv
package xcvr_avmm_pkg;

    // ****************************************
    // User and channel bus types
    // ****************************************
    typedef logic [8:0] addr_t;                 // Register address, 512 bytes per lane
    typedef logic [7:0] data_t;                 // Channel bus is one byte wide

    // Request as seen by the arbiter, the read tracker and the blocks
    typedef struct packed {
        logic  write;                           // Write strobe
        logic  read;                            // Read strobe
        addr_t address;                         // Byte address
        data_t writedata;                       // Write payload
    } avmm_req_t;

    // ****************************************
    // Read latency
    // ****************************************
    typedef logic [2:0] read_cnt_t;

    // Fixed latency of the block bus, in clocks after the first read cycle
    localparam read_cnt_t READ_LATENCY = 3'd3;
    // Held in reset, above READ_LATENCY so waitrequest stays high
    localparam read_cnt_t READ_CNT_RST = 3'd7;

    // ****************************************
    // Arbiter register at address 0
    // ****************************************
    localparam addr_t ARBITER_ADDR = 9'h000;

    localparam int ARB_CTRL_BIT = 0;            // 1 hands the bus to calibration
    localparam int CAL_DONE_BIT = 1;            // Read only, set after first calibration

    // Length of one calibration run
    localparam int CAL_CYCLES = 16;

    // Sequencer run counter, sized from CAL_CYCLES
    typedef logic [$clog2(CAL_CYCLES)-1:0] cal_cnt_t;

    // Last count of a run
    localparam cal_cnt_t CAL_CNT_LAST = cal_cnt_t'(CAL_CYCLES - 1);

endpackage
